// File: sources.f
+incdir+bench
common/pkt_word_pkg.sv
common/rx_status_pkg.sv
source/sync_fifo.sv
receive/word_packer.sv
receive/mac_rx_writer.sv
source/rx_output_reader.sv
source/rx_queue.sv
bench/rx_queue_tb.sv

// File: Bender.yml
package:
  name: rx_queue

sources:
  - files:
      - common/pkt_word_pkg.sv
      - common/rx_status_pkg.sv
      - source/sync_fifo.sv
      - receive/word_packer.sv
      - receive/mac_rx_writer.sv
      - source/rx_output_reader.sv
      - source/rx_queue.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rx_queue_tb.sv

// File: bench/rx_queue_ref.svh
`ifndef RX_QUEUE_REF_SVH
`define RX_QUEUE_REF_SVH

//////////////////////////////////////////////////
// reference model of the receive queue output
//////////////////////////////////////////////////

// eight byte lanes per 64-bit output word
localparam int REF_LANES       = 8;

// packets that reach this size are cut off and never forwarded
localparam int REF_TRUNC_BYTES = 2046;

typedef logic [7:0]  ref_byte_q_t[$];
typedef logic [63:0] ref_data_q_t[$];
typedef logic [7:0]  ref_ctrl_q_t[$];

// expected words, control bits and counts of one forwarded packet
function automatic void rx_expect(
   input  ref_byte_q_t pkt,
   output ref_data_q_t data,
   output ref_ctrl_q_t ctrl,
   output int          byte_cnt,
   output int          word_cnt
);
   logic [63:0] cur_data;
   logic [7:0]  cur_ctrl;
   int          lane;
   data     = {};
   ctrl     = {};
   cur_data = '0;
   cur_ctrl = '0;
   lane     = 0;
   foreach (pkt[i]) begin
      // first byte of a word sits in bits 7:0
      cur_data[lane*8 +: 8] = pkt[i];
      if (i == pkt.size() - 1) begin
         cur_ctrl[lane] = 1'b1;
      end
      lane++;
      if (lane == REF_LANES) begin
         data.push_back(cur_data);
         ctrl.push_back(cur_ctrl);
         cur_data = '0;
         cur_ctrl = '0;
         lane     = 0;
      end
   end
   // tail word, the unused lanes stay zero
   if (lane != 0) begin
      data.push_back(cur_data);
      ctrl.push_back(cur_ctrl);
   end
   byte_cnt = pkt.size();
   word_cnt = (byte_cnt + REF_LANES - 1) / REF_LANES;
endfunction

`endif

// File: bench/rx_queue_tb.sv
`timescale 1ns/1ps

module rx_queue_tb;

   `include "rx_queue_ref.svh"

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int WAIT_LIMIT   = 20000;
   localparam int GAP_CYCLES   = 12;
   localparam int QUIET_CYCLES = 50;
   localparam int RDY_HIGH     = 0;
   localparam int RDY_RANDOM   = 1;
   localparam int RDY_LOW      = 2;

   logic        clk;
   logic        reset;
   logic [7:0]  gmac_rx_data;
   logic        gmac_rx_dvld;
   logic        gmac_rx_goodframe;
   logic        gmac_rx_badframe;
   logic        rx_queue_en;
   logic        out_rdy;
   logic [63:0] out_data;
   logic [7:0]  out_ctrl;
   logic        out_wr;
   logic        rx_pkt_good;
   logic        rx_pkt_bad;
   logic        rx_pkt_dropped;
   logic        rx_pkt_pulled;
   logic [11:0] rx_pkt_byte_cnt;
   logic [9:0]  rx_pkt_word_cnt;

   // expected output, filled by the driver and emptied by the monitor
   logic [63:0] exp_data[$];
   logic [7:0]  exp_ctrl[$];
   int          exp_bytes[$];
   int          exp_words[$];
   int          exp_good   = 0;
   int          exp_bad    = 0;
   int          exp_drop   = 0;
   int          good_seen  = 0;
   int          bad_seen   = 0;
   int          drop_seen  = 0;
   int          rdy_mode   = RDY_HIGH;
   logic        rdy_prev   = 1'b0;

   rx_queue #(
      .DATA_DEPTH_BITS   (9),
      .STATUS_DEPTH_BITS (7)
   ) DUT (
      .clk               (clk),
      .reset             (reset),
      .gmac_rx_data      (gmac_rx_data),
      .gmac_rx_dvld      (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe),
      .gmac_rx_badframe  (gmac_rx_badframe),
      .rx_queue_en       (rx_queue_en),
      .out_rdy           (out_rdy),
      .out_data          (out_data),
      .out_ctrl          (out_ctrl),
      .out_wr            (out_wr),
      .rx_pkt_good       (rx_pkt_good),
      .rx_pkt_bad        (rx_pkt_bad),
      .rx_pkt_dropped    (rx_pkt_dropped),
      .rx_pkt_pulled     (rx_pkt_pulled),
      .rx_pkt_byte_cnt   (rx_pkt_byte_cnt),
      .rx_pkt_word_cnt   (rx_pkt_word_cnt)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2);
         clk = ~clk;
      end
   end

   //////////////////////////////////////////////////
   // error handling and checks
   //////////////////////////////////////////////////

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         stop_with_failure($sformatf("ERR %0t %s: got %0h, expected %0h",
                                    $time, name, actual, expected));
      end
   endtask

   task automatic check_counts();
      check_value("rx_pkt_good pulses", 64'(good_seen), 64'(exp_good));
      check_value("rx_pkt_bad pulses", 64'(bad_seen), 64'(exp_bad));
      check_value("rx_pkt_dropped pulses", 64'(drop_seen), 64'(exp_drop));
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_bytes.size() != 0) begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            stop_with_failure("timed out waiting for the expected packets at the output");
         end
      end
   endtask

   //////////////////////////////////////////////////
   // MAC driver
   //////////////////////////////////////////////////

   task automatic send_packet(input int len, input bit bad, input bit admitted);
      ref_byte_q_t pkt;
      ref_data_q_t data;
      ref_ctrl_q_t ctrl;
      int          byte_cnt;
      int          word_cnt;
      int          delay;
      for (int i = 0; i < len; i++) begin
         pkt.push_back(8'($urandom));
      end
      delay = 1 + int'($urandom % 5);
      if (!admitted) begin
         exp_drop++;
      end else if (bad || len >= REF_TRUNC_BYTES) begin
         exp_bad++;
      end else begin
         exp_good++;
         rx_expect(pkt, data, ctrl, byte_cnt, word_cnt);
         foreach (data[i]) begin
            exp_data.push_back(data[i]);
            exp_ctrl.push_back(ctrl[i]);
         end
         exp_bytes.push_back(byte_cnt);
         exp_words.push_back(word_cnt);
      end
      foreach (pkt[i]) begin
         @(posedge clk);
         #DRIVE_DELAY;
         gmac_rx_dvld = 1'b1;
         gmac_rx_data = pkt[i];
      end
      @(posedge clk);
      #DRIVE_DELAY;
      gmac_rx_dvld = 1'b0;
      gmac_rx_data = 8'h00;
      // frame verdict some cycles after valid falls
      repeat (delay) @(posedge clk);
      #DRIVE_DELAY;
      gmac_rx_goodframe = !bad;
      gmac_rx_badframe  = bad;
      @(posedge clk);
      #DRIVE_DELAY;
      gmac_rx_goodframe = 1'b0;
      gmac_rx_badframe  = 1'b0;
      repeat (GAP_CYCLES) @(posedge clk);
   endtask

   function automatic int random_length();
      return 60 + int'($urandom % 1441);
   endfunction

   // out_rdy pattern
   initial begin
      out_rdy = 1'b1;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         case (rdy_mode)
            RDY_RANDOM: out_rdy = ($urandom % 2) != 0;
            RDY_LOW:    out_rdy = 1'b0;
            default:    out_rdy = 1'b1;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // output monitor and compare
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      if (!reset) begin
         if (rx_pkt_good) good_seen++;
         if (rx_pkt_bad) bad_seen++;
         if (rx_pkt_dropped) drop_seen++;
         if (out_wr) begin
            if (!rdy_prev) begin
               stop_with_failure("out_wr went high one cycle after out_rdy was low");
            end
            if (exp_data.size() == 0) begin
               stop_with_failure("an output word appeared with no packet expected");
            end
            check_value("out_data", out_data, exp_data.pop_front());
            check_value("out_ctrl", 64'(out_ctrl), 64'(exp_ctrl.pop_front()));
         end
         if (rx_pkt_pulled) begin
            if (exp_bytes.size() == 0) begin
               stop_with_failure("rx_pkt_pulled pulsed with no packet expected");
            end
            check_value("rx_pkt_byte_cnt", 64'(rx_pkt_byte_cnt), 64'(exp_bytes.pop_front()));
            check_value("rx_pkt_word_cnt", 64'(rx_pkt_word_cnt), 64'(exp_words.pop_front()));
         end
      end
      rdy_prev = out_rdy;
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h2634));
      reset             = 1'b1;
      gmac_rx_data      = 8'h00;
      gmac_rx_dvld      = 1'b0;
      gmac_rx_goodframe = 1'b0;
      gmac_rx_badframe  = 1'b0;
      rx_queue_en       = 1'b1;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      repeat (5) @(posedge clk);

      // good packets at full rate
      repeat (4) send_packet(random_length(), 1'b0, 1'b1);
      wait_drain();
      check_counts();

      // bad verdict, then a good packet behind it
      send_packet(random_length(), 1'b1, 1'b1);
      send_packet(random_length(), 1'b0, 1'b1);
      wait_drain();
      check_counts();

      // queue disabled
      @(posedge clk);
      #DRIVE_DELAY;
      rx_queue_en = 1'b0;
      send_packet(random_length(), 1'b0, 1'b0);
      #DRIVE_DELAY;
      rx_queue_en = 1'b1;
      wait_drain();
      check_counts();

      // oversize packet is cut off
      send_packet(2100, 1'b0, 1'b1);
      send_packet(random_length(), 1'b0, 1'b1);
      wait_drain();
      check_counts();

      // random back-pressure
      rdy_mode = RDY_RANDOM;
      repeat (4) send_packet(random_length(), 1'b0, 1'b1);
      wait_drain();
      check_counts();

      // full data FIFO drops the third packet
      rdy_mode = RDY_LOW;
      send_packet(1500, 1'b0, 1'b1);
      send_packet(1500, 1'b0, 1'b1);
      send_packet(1500, 1'b0, 1'b0);
      check_counts();
      check_value("packets held with out_rdy low", 64'(exp_bytes.size()), 64'd2);
      rdy_mode = RDY_HIGH;
      wait_drain();
      repeat (QUIET_CYCLES) @(posedge clk);
      check_counts();

      if (exp_data.size() == 0 && exp_bytes.size() == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         stop_with_failure("expected output words are still pending at the end of the run");
      end
   end

endmodule

// File: source/rx_queue.sv
`timescale 1ns/1ps

module rx_queue #(
   parameter int DATA_DEPTH_BITS   = 9,
   parameter int STATUS_DEPTH_BITS = 7
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [7:0]                          gmac_rx_data,
   input  logic                                gmac_rx_dvld,
   input  logic                                gmac_rx_goodframe,
   input  logic                                gmac_rx_badframe,
   input  logic                                rx_queue_en,
   input  logic                                out_rdy,
   output logic [pkt_word_pkg::DATA_WIDTH-1:0] out_data,
   output logic [pkt_word_pkg::CTRL_WIDTH-1:0] out_ctrl,
   output logic                                out_wr,
   output logic                                rx_pkt_good,
   output logic                                rx_pkt_bad,
   output logic                                rx_pkt_dropped,
   output logic                                rx_pkt_pulled,
   output rx_status_pkg::byte_cnt_t            rx_pkt_byte_cnt,
   output rx_status_pkg::word_cnt_t            rx_pkt_word_cnt
);

   import pkt_word_pkg::*;
   import rx_status_pkg::*;

   // writer to packer
   logic        byte_wr;
   logic [7:0]  byte_data;
   logic        byte_eop;

   // data path
   logic        word_push;
   pkt_word_t   word_in;
   pkt_word_t   word_out;
   logic        word_pop;
   logic        word_empty;
   logic        data_room;

   // status path
   logic        stat_push;
   pkt_status_t stat_in;
   pkt_status_t stat_out;
   logic        stat_pop;
   logic        stat_empty;

   //////////////////////////////////////////////////
   // MAC side
   //////////////////////////////////////////////////

   mac_rx_writer writer (
      .clk               (clk),
      .reset             (reset),
      .gmac_rx_data      (gmac_rx_data),
      .gmac_rx_dvld      (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe),
      .gmac_rx_badframe  (gmac_rx_badframe),
      .rx_queue_en       (rx_queue_en),
      .room              (data_room),
      .byte_wr           (byte_wr),
      .byte_data         (byte_data),
      .byte_eop          (byte_eop),
      .stat_push         (stat_push),
      .stat              (stat_in),
      .rx_pkt_good       (rx_pkt_good),
      .rx_pkt_bad        (rx_pkt_bad),
      .rx_pkt_dropped    (rx_pkt_dropped)
   );

   word_packer packer (
      .clk       (clk),
      .reset     (reset),
      .byte_wr   (byte_wr),
      .byte_data (byte_data),
      .byte_eop  (byte_eop),
      .word_push (word_push),
      .word      (word_in)
   );

   //////////////////////////////////////////////////
   // queues
   //////////////////////////////////////////////////

   // room flag held high while a maximum-size packet still fits
   sync_fifo #(
      .DEPTH_BITS (DATA_DEPTH_BITS),
      .payload_t  (pkt_word_t),
      .ROOM_WORDS (MAX_PKT_WORDS + 1)
   ) data_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (word_push),
      .din   (word_in),
      .pop   (word_pop),
      .dout  (word_out),
      .empty (word_empty),
      .full  (),
      .room  (data_room)
   );

   sync_fifo #(
      .DEPTH_BITS (STATUS_DEPTH_BITS),
      .payload_t  (pkt_status_t),
      .ROOM_WORDS (1)
   ) status_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (stat_push),
      .din   (stat_in),
      .pop   (stat_pop),
      .dout  (stat_out),
      .empty (stat_empty),
      .full  (),
      .room  ()
   );

   //////////////////////////////////////////////////
   // output side
   //////////////////////////////////////////////////

   rx_output_reader reader (
      .clk             (clk),
      .reset           (reset),
      .stat            (stat_out),
      .stat_empty      (stat_empty),
      .word            (word_out),
      .word_empty      (word_empty),
      .out_rdy         (out_rdy),
      .stat_pop        (stat_pop),
      .word_pop        (word_pop),
      .out_data        (out_data),
      .out_ctrl        (out_ctrl),
      .out_wr          (out_wr),
      .rx_pkt_pulled   (rx_pkt_pulled),
      .rx_pkt_byte_cnt (rx_pkt_byte_cnt),
      .rx_pkt_word_cnt (rx_pkt_word_cnt)
   );

endmodule

// File: source/rx_output_reader.sv
`timescale 1ns/1ps

module rx_output_reader (
   input  logic                                  clk,
   input  logic                                  reset,
   input  rx_status_pkg::pkt_status_t            stat,
   input  logic                                  stat_empty,
   input  pkt_word_pkg::pkt_word_t               word,
   input  logic                                  word_empty,
   input  logic                                  out_rdy,
   output logic                                  stat_pop,
   output logic                                  word_pop,
   output logic [pkt_word_pkg::DATA_WIDTH-1:0]   out_data,
   output logic [pkt_word_pkg::CTRL_WIDTH-1:0]   out_ctrl,
   output logic                                  out_wr,
   output logic                                  rx_pkt_pulled,
   output rx_status_pkg::byte_cnt_t              rx_pkt_byte_cnt,
   output rx_status_pkg::word_cnt_t              rx_pkt_word_cnt
);

   import pkt_word_pkg::*;
   import rx_status_pkg::*;

   typedef enum logic {
      OUT_WAIT_PKT,
      OUT_STREAM
   } out_state_t;

   out_state_t  state;
   out_state_t  state_nxt;
   pkt_status_t cur_stat;
   word_cnt_t   word_cnt;
   logic        send;
   logic        last;

   //////////////////////////////////////////////////
   // forward or discard
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      stat_pop  = 1'b0;
      word_pop  = 1'b0;
      send      = 1'b0;
      last      = 1'b0;

      case (state)
         OUT_WAIT_PKT: begin
            if (!stat_empty) begin
               stat_pop  = 1'b1;
               state_nxt = OUT_STREAM;
            end
         end

         OUT_STREAM: begin
            // bad packets drain one word per cycle regardless of out_rdy
            if (out_rdy || !cur_stat.good) begin
               word_pop = 1'b1;
               send     = cur_stat.good;
               if (|word.ctrl) begin
                  last      = 1'b1;
                  state_nxt = OUT_WAIT_PKT;
               end
            end
         end

         default: state_nxt = OUT_WAIT_PKT;
      endcase
   end

   // byte count over 8, rounded up
   assign word_cnt = word_cnt_t'(cur_stat.byte_cnt >> LANE_BITS)
                   + word_cnt_t'(|cur_stat.byte_cnt[LANE_BITS-1:0]);

   //////////////////////////////////////////////////
   // registered outputs
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      out_data        <= word.data;
      out_ctrl        <= word.ctrl;
      rx_pkt_byte_cnt <= cur_stat.byte_cnt;
      rx_pkt_word_cnt <= word_cnt;
      if (stat_pop) begin
         cur_stat <= stat;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= OUT_WAIT_PKT;
         out_wr        <= 1'b0;
         rx_pkt_pulled <= 1'b0;
      end else begin
         state         <= state_nxt;
         out_wr        <= send;
         rx_pkt_pulled <= send && last;
      end
   end

   // status is queued after its words, so a popped status implies data
   assert property (@(posedge clk) disable iff (reset) word_pop |-> !word_empty);

endmodule

// File: receive/mac_rx_writer.sv
`timescale 1ns/1ps

module mac_rx_writer (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [7:0]                 gmac_rx_data,
   input  logic                       gmac_rx_dvld,
   input  logic                       gmac_rx_goodframe,
   input  logic                       gmac_rx_badframe,
   input  logic                       rx_queue_en,
   input  logic                       room,
   output logic                       byte_wr,
   output logic [7:0]                 byte_data,
   output logic                       byte_eop,
   output logic                       stat_push,
   output rx_status_pkg::pkt_status_t stat,
   output logic                       rx_pkt_good,
   output logic                       rx_pkt_bad,
   output logic                       rx_pkt_dropped
);

   import pkt_word_pkg::*;
   import rx_status_pkg::*;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_RECEIVE,
      RX_WAIT_VERDICT,
      RX_PAD,
      RX_DROP
   } rx_state_t;

   rx_state_t            state;
   rx_state_t            state_nxt;
   logic [7:0]           data_d1;
   logic                 dvld_d1;
   byte_cnt_t            byte_cnt;
   logic [LANE_BITS-1:0] lane;
   logic                 good_q;
   logic                 trunc_q;
   logic                 wr_nxt;
   logic                 eop_nxt;
   logic                 pad_nxt;
   logic                 trunc_nxt;

   //////////////////////////////////////////////////
   // packet state machine
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt      = state;
      wr_nxt         = 1'b0;
      eop_nxt        = 1'b0;
      pad_nxt        = 1'b0;
      trunc_nxt      = 1'b0;
      stat_push      = 1'b0;
      rx_pkt_good    = 1'b0;
      rx_pkt_bad     = 1'b0;
      rx_pkt_dropped = 1'b0;

      case (state)
         RX_IDLE: begin
            // admit only with room for a maximum-size packet
            if (dvld_d1 && room && rx_queue_en) begin
               wr_nxt    = 1'b1;
               state_nxt = RX_RECEIVE;
               if (!gmac_rx_dvld) begin
                  eop_nxt   = 1'b1;
                  state_nxt = RX_WAIT_VERDICT;
               end
            end else if (dvld_d1) begin
               rx_pkt_dropped = 1'b1;
               state_nxt      = RX_DROP;
            end
         end

         RX_RECEIVE: begin
            wr_nxt = 1'b1;
            // reaching the limit cuts the packet off even on its last byte
            if (byte_cnt == byte_cnt_t'(TRUNC_LIMIT - 1)) begin
               eop_nxt    = 1'b1;
               trunc_nxt  = 1'b1;
               rx_pkt_bad = 1'b1;
               state_nxt  = RX_PAD;
            end else if (!gmac_rx_dvld) begin
               // raw valid low means the registered byte is the last one
               eop_nxt   = 1'b1;
               state_nxt = RX_WAIT_VERDICT;
            end
         end

         // fcs verdict comes some cycles after valid falls
         RX_WAIT_VERDICT: begin
            if (gmac_rx_goodframe) begin
               rx_pkt_good = 1'b1;
               state_nxt   = RX_PAD;
            end else if (gmac_rx_badframe) begin
               rx_pkt_bad = 1'b1;
               state_nxt  = RX_PAD;
            end
         end

         RX_PAD: begin
            if (lane == '0) begin
               stat_push = 1'b1;
               // a cut-off packet still has its tail on the wire
               state_nxt = (trunc_q && dvld_d1) ? RX_DROP : RX_IDLE;
            end else begin
               wr_nxt  = 1'b1;
               pad_nxt = 1'b1;
            end
         end

         RX_DROP: begin
            if (!dvld_d1) begin
               state_nxt = RX_IDLE;
            end
         end

         default: state_nxt = RX_IDLE;
      endcase
   end

   //////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      data_d1   <= gmac_rx_data;
      byte_data <= pad_nxt ? 8'h00 : data_d1;
      byte_eop  <= eop_nxt;
      if (rx_pkt_good) begin
         good_q <= 1'b1;
      end else if (rx_pkt_bad) begin
         good_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= RX_IDLE;
         dvld_d1  <= 1'b0;
         byte_wr  <= 1'b0;
         byte_cnt <= '0;
         lane     <= '0;
         trunc_q  <= 1'b0;
      end else begin
         state   <= state_nxt;
         dvld_d1 <= gmac_rx_dvld;
         byte_wr <= wr_nxt;
         // lane counts pad bytes too, byte count only real ones
         if (wr_nxt) begin
            lane <= lane + 1'b1;
         end
         if (stat_push) begin
            byte_cnt <= '0;
         end else if (wr_nxt && !pad_nxt) begin
            byte_cnt <= byte_cnt + 1'b1;
         end
         if (trunc_nxt) begin
            trunc_q <= 1'b1;
         end else if (stat_push) begin
            trunc_q <= 1'b0;
         end
      end
   end

   assign stat = '{good: good_q, byte_cnt: byte_cnt};

   // writes only follow an admit, so never with the FSM back in idle
   assert property (@(posedge clk) disable iff (reset) byte_wr |-> state != RX_IDLE);

endmodule

// File: receive/word_packer.sv
`timescale 1ns/1ps

module word_packer (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    byte_wr,
   input  logic [7:0]              byte_data,
   input  logic                    byte_eop,
   output logic                    word_push,
   output pkt_word_pkg::pkt_word_t word
);

   import pkt_word_pkg::*;

   logic [LANE_BITS-1:0] lane;
   pkt_word_t            partial;

   //////////////////////////////////////////////////
   // lane insert
   //////////////////////////////////////////////////

   // partial word with the incoming byte merged into the current lane
   always_comb begin
      word = partial;
      word.data[lane*LANE_WIDTH +: LANE_WIDTH] = byte_data;
      word.ctrl[lane] = byte_eop;
   end

   // full once the top lane is written
   assign word_push = byte_wr && (lane == LANE_BITS'(CTRL_WIDTH - 1));

   //////////////////////////////////////////////////
   // lane index and partial word
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (byte_wr) begin
         partial <= word_push ? '0 : word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         lane <= '0;
      end else if (byte_wr) begin
         // wraps back to lane 0 after the push
         lane <= lane + 1'b1;
      end
   end

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
   parameter int  DEPTH_BITS = 4,
   parameter type payload_t  = logic [7:0],
   parameter int  ROOM_WORDS = 1
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     push,
   input  payload_t din,
   input  logic     pop,
   output payload_t dout,
   output logic     empty,
   output logic     full,
   output logic     room
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   payload_t              mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  wr_en;
   logic                  rd_en;

   assign wr_en = push && !full;
   assign rd_en = pop && !empty;

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   // show-ahead, head entry is always on dout
   assign dout = mem[rd_ptr];

   //////////////////////////////////////////////////
   // pointers and occupancy
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign empty = (count == '0);
   assign full  = (count == DEPTH[DEPTH_BITS:0]);

   // enough free entries left for a whole packet
   assign room  = (DEPTH - int'(count)) >= ROOM_WORDS;

   // writers must respect full, readers must respect empty
   assert property (@(posedge clk) disable iff (reset) push |-> !full);
   assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// File: common/rx_status_pkg.sv
package rx_status_pkg;

   //////////////////////////////////////////////////
   // packet size limits
   //////////////////////////////////////////////////

   localparam int MAX_PKT_SIZE  = 2048;

   // packets are cut off once they reach this many bytes
   localparam int TRUNC_LIMIT   = MAX_PKT_SIZE - 2;

   // eight bytes per queued word
   localparam int MAX_PKT_WORDS = MAX_PKT_SIZE / 8;

   //////////////////////////////////////////////////
   // count types
   //////////////////////////////////////////////////

   localparam int BYTE_CNT_BITS = $clog2(MAX_PKT_SIZE) + 1;
   localparam int WORD_CNT_BITS = 10;

   typedef logic [BYTE_CNT_BITS-1:0] byte_cnt_t;
   typedef logic [WORD_CNT_BITS-1:0] word_cnt_t;

   // one entry per finished packet, byte count excludes padding
   typedef struct packed {
      logic      good;
      byte_cnt_t byte_cnt;
   } pkt_status_t;

endpackage

// File: common/pkt_word_pkg.sv
package pkt_word_pkg;

   //////////////////////////////////////////////////
   // output bus format
   //////////////////////////////////////////////////

   // 64-bit data word, one control bit per byte lane
   localparam int DATA_WIDTH = 64;
   localparam int CTRL_WIDTH = DATA_WIDTH / 8;

   // lane layout, lane 0 sits in bits 7:0
   localparam int LANE_WIDTH = DATA_WIDTH / CTRL_WIDTH;
   localparam int LANE_BITS  = $clog2(CTRL_WIDTH);

   // one queued word with its control bits
   // a control bit is set only on the lane of the last real byte
   typedef struct packed {
      logic [CTRL_WIDTH-1:0] ctrl;
      logic [DATA_WIDTH-1:0] data;
   } pkt_word_t;

endpackage
